// File: Makefile
# Verilator flow for the operand fetch stage.
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= operandFetchTb
RTL_TOP   ?= operandFetch
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= No errors

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/operandFetchTb.sv
`include "operand_config.svh"

module operandFetchTb;

    localparam int RAND_CYCLES     = 400;  // random test length.
    localparam int DIRECTED_CYCLES = 40;   // tests 2 to 5 with their drains.
    localparam int MARGIN          = 50;
    localparam int LIMIT = 2 + (`NUM_REGS + 3) + DIRECTED_CYCLES + (RAND_CYCLES + 3) + MARGIN;

    logic            clk;
    logic            rst;
    logic            readValid;
    archPkg::regIdxT rs1;
    archPkg::regIdxT rs2;
    logic            decWen;
    archPkg::regIdxT decRd;
    robPkg::robTagT  decTag;
    logic            cdbValid;
    robPkg::robTagT  cdbTag;
    archPkg::wordT   cdbData;
    logic            commitValid;
    archPkg::regIdxT commitRd;
    robPkg::robTagT  commitTag;
    archPkg::wordT   commitData;
    logic            outValid;
    robPkg::opReadyT op1Ready;
    archPkg::wordT   op1Val;
    robPkg::robTagT  op1Tag;
    robPkg::opReadyT op2Ready;
    archPkg::wordT   op2Val;
    robPkg::robTagT  op2Tag;

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    archPkg::wordT   mVal   [`NUM_REGS];   // committed values.
    robPkg::robTagT  mTag   [`NUM_REGS];   // pending writer per register.
    archPkg::wordT   mData  [`ROB_DEPTH];  // broadcast results.
    logic            mReady [`ROB_DEPTH];

    logic            s1Valid;  // read captured, one cycle in.
    archPkg::wordT   s1Val1, s1Val2;
    robPkg::robTagT  s1Tag1, s1Tag2;
    logic            expValid;  // expected output, two cycles in.
    logic            expReady1, expReady2;
    archPkg::wordT   expVal1, expVal2;
    robPkg::robTagT  expTag1, expTag2;
    logic            modelHit;
    logic            resReady;
    archPkg::wordT   resVal;
    robPkg::robTagT  resTag;

    logic [15:0] lfsr;
    int errors;
    int checks;
    int cycles;
    int errStart;
    int chkStart;

    operandFetch uut (.*);

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic int pickTag();
        return takeBits(3) + 1;  // small range, many collisions.
    endfunction

    // value, finished result or pending tag, as seen during the lookup cycle.
    function automatic void resolveOperand(input robPkg::robTagT tag,
            input archPkg::wordT rfVal, output logic ready,
            output archPkg::wordT val, output robPkg::robTagT waitTag);
        logic present;
        archPkg::wordT result;
        present = mReady[tag];
        result  = mData[tag];
        if (cdbValid && cdbTag == tag) begin
            present = 1'b1;
            result  = cdbData;
        end
        ready   = (tag == '0) || present;
        val     = (tag == '0) ? rfVal : (present ? result : '0);
        waitTag = ready ? '0 : tag;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                mVal[i] = '0;
                mTag[i] = '0;
            end
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                mData[i]  = '0;
                mReady[i] = 1'b0;
            end
            s1Valid  <= 1'b0;
            expValid <= 1'b0;
        end else begin
            if (expValid) checks++;
            expValid <= s1Valid;
            if (s1Valid) begin
                resolveOperand(s1Tag1, s1Val1, resReady, resVal, resTag);
                expReady1 <= resReady;
                expVal1   <= resVal;
                expTag1   <= resTag;
                resolveOperand(s1Tag2, s1Val2, resReady, resVal, resTag);
                expReady2 <= resReady;
                expVal2   <= resVal;
                expTag2   <= resTag;
            end
            // a commit only counts while its tag is still the newest one.
            modelHit = commitValid && commitRd != '0 && commitTag != '0
                    && mTag[commitRd] == commitTag;
            s1Valid <= readValid;
            if (readValid) begin
                s1Val1 <= (modelHit && commitRd == rs1) ? commitData : mVal[rs1];
                s1Tag1 <= (modelHit && commitRd == rs1) ? '0 : mTag[rs1];
                s1Val2 <= (modelHit && commitRd == rs2) ? commitData : mVal[rs2];
                s1Tag2 <= (modelHit && commitRd == rs2) ? '0 : mTag[rs2];
            end
            if (modelHit) begin
                mVal[commitRd] = commitData;
                mTag[commitRd] = '0;
            end
            if (decWen && decRd != '0 && decTag != '0) mTag[decRd] = decTag;  // rename wins.
            if (decWen && decTag != '0) mReady[decTag] = 1'b0;
            if (cdbValid) begin
                mData[cdbTag]  = cdbData;
                mReady[cdbTag] = 1'b1;  // completion beats a same-tag dispatch.
            end
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    outValidMatch: assert property (@(posedge clk) disable iff (rst) outValid == expValid)
        else begin
            errors++;
            $display("[ERROR] %0t: outValid %0b, expected %0b",
                     $time, $sampled(outValid), $sampled(expValid));
        end

    op1Match: assert property (@(posedge clk) disable iff (rst)
        expValid |-> op1Ready == expReady1 && op1Val == expVal1 && op1Tag == expTag1)
        else begin
            errors++;
            $display("[ERROR] %0t: op1 ready %0b val %h tag %0d, expected %0b %h %0d",
                     $time, $sampled(op1Ready), $sampled(op1Val), $sampled(op1Tag),
                     $sampled(expReady1), $sampled(expVal1), $sampled(expTag1));
        end

    op2Match: assert property (@(posedge clk) disable iff (rst)
        expValid |-> op2Ready == expReady2 && op2Val == expVal2 && op2Tag == expTag2)
        else begin
            errors++;
            $display("[ERROR] %0t: op2 ready %0b val %h tag %0d, expected %0b %h %0d",
                     $time, $sampled(op2Ready), $sampled(op2Val), $sampled(op2Tag),
                     $sampled(expReady2), $sampled(expVal2), $sampled(expTag2));
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic step();
        @(posedge clk);
        #1;
        readValid   = 1'b0;
        decWen      = 1'b0;
        cdbValid    = 1'b0;
        commitValid = 1'b0;
    endtask

    task automatic setRead(input int a, input int b);
        readValid = 1'b1;
        rs1       = archPkg::regIdxT'(a);
        rs2       = archPkg::regIdxT'(b);
    endtask

    task automatic setDispatch(input int rd, input int tag);
        decWen = 1'b1;
        decRd  = archPkg::regIdxT'(rd);
        decTag = robPkg::robTagT'(tag);
    endtask

    task automatic setComplete(input int tag);
        cdbValid = 1'b1;
        cdbTag   = robPkg::robTagT'(tag);
        cdbData  = takeBits(32);
    endtask

    task automatic setCommit(input int rd, input int tag);
        commitValid = 1'b1;
        commitRd    = archPkg::regIdxT'(rd);
        commitTag   = robPkg::robTagT'(tag);
        commitData  = takeBits(32);
    endtask

    // wait until every read in flight has reached the output.
    task automatic drain();
        step();
        while (s1Valid || expValid) step();
    endtask

    task automatic startTest();
        errStart = errors;
        chkStart = checks;
    endtask

    task automatic finishTest(input string name);
        $display("%-14s %0d checks, %0d errors", name, checks - chkStart, errors - errStart);
    endtask

    initial begin
        archPkg::regIdxT rd;
        clk = 1'b0;
        rst = 1'b1;
        lfsr = 16'd51722;
        errors = 0;
        checks = 0;
        cycles = 0;
        readValid = 1'b0;
        rs1 = '0;
        rs2 = '0;
        decWen = 1'b0;
        decRd = '0;
        decTag = '0;
        cdbValid = 1'b0;
        cdbTag = '0;
        cdbData = '0;
        commitValid = 1'b0;
        commitRd = '0;
        commitTag = '0;
        commitData = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        startTest();
        for (int r = 0; r < `NUM_REGS; r++) begin
            setRead(r, `NUM_REGS - 1 - r);
            step();
        end
        drain();
        finishTest("reset state");

        startTest();
        setDispatch(5, 7);
        setRead(5, 5);  // sees the old tag.
        step();
        setRead(5, 6);
        step();
        drain();
        finishTest("dispatch");

        startTest();
        setComplete(7);
        step();
        setRead(5, 0);
        step();
        setDispatch(6, 9);
        step();
        setRead(6, 6);
        step();
        setComplete(9);  // lands in the lookup cycle.
        step();
        drain();
        finishTest("completion");

        startTest();
        setCommit(5, 7);
        step();
        setRead(5, 5);
        step();
        setDispatch(5, 10);
        step();
        setDispatch(5, 11);
        step();
        setCommit(5, 10);  // stale.
        step();
        setRead(5, 5);
        step();
        setCommit(5, 11);
        setRead(5, 3);
        step();
        setDispatch(6, 12);
        setCommit(6, 9);
        step();
        setRead(6, 6);
        step();
        drain();
        finishTest("commit");

        startTest();
        setDispatch(0, 13);
        step();
        setCommit(0, 13);
        step();
        setComplete(13);
        setRead(0, 0);
        step();
        setRead(0, 6);
        step();
        drain();
        finishTest("x0");

        startTest();
        for (int i = 0; i < RAND_CYCLES; i++) begin
            setRead(takeBits(5), takeBits(5));
            if (takeBits(1) != 0) setDispatch(takeBits(5), pickTag());
            if (takeBits(1) != 0) setComplete(pickTag());
            if (takeBits(1) != 0) begin
                rd = archPkg::regIdxT'(takeBits(5));
                // mostly the live tag, sometimes a stale one.
                if (mTag[rd] != '0 && takeBits(2) != 0) setCommit(int'(rd), int'(mTag[rd]));
                else setCommit(int'(rd), pickTag());
            end
            step();
        end
        drain();
        finishTest("random");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: rtl/archPkg.sv
`include "operand_config.svh"

package archPkg;

    // register index wide enough for every architectural register.
    typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;

    // one data word as held in the register file.
    typedef logic [`XLEN-1:0] wordT;

endpackage

// File: rtl/operandFetch.sv
module operandFetch (
    input  logic            clk,
    input  logic            rst,
    input  logic            readValid,
    input  archPkg::regIdxT rs1,
    input  archPkg::regIdxT rs2,
    input  logic            decWen,
    input  archPkg::regIdxT decRd,
    input  robPkg::robTagT  decTag,
    input  logic            cdbValid,
    input  robPkg::robTagT  cdbTag,
    input  archPkg::wordT   cdbData,
    input  logic            commitValid,
    input  archPkg::regIdxT commitRd,
    input  robPkg::robTagT  commitTag,
    input  archPkg::wordT   commitData,
    output logic            outValid,
    output robPkg::opReadyT op1Ready,
    output archPkg::wordT   op1Val,
    output robPkg::robTagT  op1Tag,
    output robPkg::opReadyT op2Ready,
    output archPkg::wordT   op2Val,
    output robPkg::robTagT  op2Tag
);

    logic            rfValid;
    archPkg::wordT   rfVal1, rfVal2;
    robPkg::robTagT  rfTag1, rfTag2;
    robPkg::robTagT  lookTag1, lookTag2;
    robPkg::opReadyT robReady1, robReady2;
    archPkg::wordT   robData1, robData2;

    regFile rf (
        .clk, .rst, .readValid, .rs1, .rs2,
        .decWen, .decRd, .decTag,
        .commitValid, .commitRd, .commitTag, .commitData,
        .rfValid, .rfVal1, .rfVal2, .rfTag1, .rfTag2
    );

    robValues rob (
        .clk, .rst, .decWen, .decTag,
        .cdbValid, .cdbTag, .cdbData,
        .lookTag1, .lookTag2,
        .robReady1, .robReady2, .robData1, .robData2
    );

    operandSelect sel (
        .clk, .rst, .rfValid, .rfVal1, .rfVal2, .rfTag1, .rfTag2,
        .robReady1, .robReady2, .robData1, .robData2,
        .lookTag1, .lookTag2, .outValid,
        .op1Ready, .op1Val, .op1Tag, .op2Ready, .op2Val, .op2Tag
    );

endmodule

// File: rtl/operandSelect.sv
module operandSelect (
    input  logic            clk,
    input  logic            rst,
    input  logic            rfValid,
    input  archPkg::wordT   rfVal1,
    input  archPkg::wordT   rfVal2,
    input  robPkg::robTagT  rfTag1,
    input  robPkg::robTagT  rfTag2,
    input  robPkg::opReadyT robReady1,
    input  robPkg::opReadyT robReady2,
    input  archPkg::wordT   robData1,
    input  archPkg::wordT   robData2,
    output robPkg::robTagT  lookTag1,
    output robPkg::robTagT  lookTag2,
    output logic            outValid,
    output robPkg::opReadyT op1Ready,
    output archPkg::wordT   op1Val,
    output robPkg::robTagT  op1Tag,
    output robPkg::opReadyT op2Ready,
    output archPkg::wordT   op2Val,
    output robPkg::robTagT  op2Tag
);

    // committed value, finished result, or the tag to wait on.
    function automatic void pickOperand(
        input  robPkg::robTagT  tag,
        input  archPkg::wordT   rfVal,
        input  robPkg::opReadyT robReady,
        input  archPkg::wordT   robData,
        output robPkg::opReadyT ready,
        output archPkg::wordT   val,
        output robPkg::robTagT  waitTag
    );
        ready   = 1'b1;
        val     = rfVal;
        waitTag = '0;
        if (tag != '0) begin
            ready   = robReady;
            val     = robReady ? robData : '0;
            waitTag = robReady ? '0 : tag;
        end
    endfunction

    assign lookTag1 = rfTag1;
    assign lookTag2 = rfTag2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= rfValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rfValid) begin
            pickOperand(rfTag1, rfVal1, robReady1, robData1, op1Ready, op1Val, op1Tag);
            pickOperand(rfTag2, rfVal2, robReady2, robData2, op2Ready, op2Val, op2Tag);
        end
    end

    readyHasNoTag: assert property (@(posedge clk) disable iff (rst)
        outValid |-> !(op1Ready && op1Tag != '0) && !(op2Ready && op2Tag != '0))
        else $error("ready operand carries a tag");

endmodule

// File: rtl/operand_config.svh
`ifndef OPERAND_CONFIG_SVH
`define OPERAND_CONFIG_SVH

// ----------------------------------------
// architectural state
// ----------------------------------------
`define NUM_REGS 32   // architectural registers.
`define XLEN 32       // data word width.

// ----------------------------------------
// reorder buffer, tag 0 means no writer
// ----------------------------------------
`define TAG_W 5       // tag width.
`define ROB_DEPTH 32  // entries, valid tags 1..31.

`endif

// File: rtl/regFile.sv
`include "operand_config.svh"

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  logic            readValid,
    input  archPkg::regIdxT rs1,
    input  archPkg::regIdxT rs2,
    input  logic            decWen,
    input  archPkg::regIdxT decRd,
    input  robPkg::robTagT  decTag,
    input  logic            commitValid,
    input  archPkg::regIdxT commitRd,
    input  robPkg::robTagT  commitTag,
    input  archPkg::wordT   commitData,
    output logic            rfValid,
    output archPkg::wordT   rfVal1,
    output archPkg::wordT   rfVal2,
    output robPkg::robTagT  rfTag1,
    output robPkg::robTagT  rfTag2
);

    archPkg::wordT  regVals [`NUM_REGS];  // committed values.
    robPkg::robTagT regTags [`NUM_REGS];  // newest pending writer.

    logic commitHit;
    logic decHit;
    logic bypass1;
    logic bypass2;

    // commit only counts while its tag is still the newest writer.
    assign commitHit = commitValid && commitRd != '0 && commitTag != '0
                    && regTags[commitRd] == commitTag;
    assign decHit = decWen && decRd != '0 && decTag != '0;  // x0 never renamed.

    assign bypass1 = commitHit && commitRd == rs1;
    assign bypass2 = commitHit && commitRd == rs2;

    // ----------------------------------------
    // state update
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regVals[i] <= '0;
                regTags[i] <= '0;
            end
        end else begin
            if (commitHit) begin
                regVals[commitRd] <= commitData;
                regTags[commitRd] <= '0;
            end
            if (decHit) begin
                regTags[decRd] <= decTag;  // overrides a same-cycle clear.
            end
        end
    end

    // ----------------------------------------
    // registered read ports
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfValid <= 1'b0;
        end else begin
            rfValid <= readValid;
        end
    end

    // same-cycle commit is forwarded, same-cycle dispatch is not.
    always_ff @(posedge clk) begin
        if (readValid) begin
            rfVal1 <= bypass1 ? commitData : regVals[rs1];
            rfVal2 <= bypass2 ? commitData : regVals[rs2];
            rfTag1 <= bypass1 ? '0 : regTags[rs1];
            rfTag2 <= bypass2 ? '0 : regTags[rs2];
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    commitTagNonZero: assert property (@(posedge clk) disable iff (rst)
        commitValid |-> commitTag != '0)
        else $error("commit carries tag 0");

endmodule

// File: rtl/robPkg.sv
`include "operand_config.svh"

package robPkg;

    // reorder buffer tag, zero is reserved for no pending writer.
    typedef logic [`TAG_W-1:0] robTagT;

    // operand ready flag, set once the value is known.
    typedef logic opReadyT;

endpackage

// File: rtl/robValues.sv
`include "operand_config.svh"

module robValues (
    input  logic             clk,
    input  logic             rst,
    input  logic             decWen,
    input  robPkg::robTagT   decTag,
    input  logic             cdbValid,
    input  robPkg::robTagT   cdbTag,
    input  archPkg::wordT    cdbData,
    input  robPkg::robTagT   lookTag1,
    input  robPkg::robTagT   lookTag2,
    output robPkg::opReadyT  robReady1,
    output robPkg::opReadyT  robReady2,
    output archPkg::wordT    robData1,
    output archPkg::wordT    robData2
);

    archPkg::wordT   results [`ROB_DEPTH];  // broadcast results.
    robPkg::opReadyT done    [`ROB_DEPTH];  // result present.

    logic hit1;
    logic hit2;

    // ----------------------------------------
    // dispatch clears, completion fills
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                results[i] <= '0;
                done[i]    <= 1'b0;
            end
        end else begin
            if (decWen && decTag != '0) begin
                done[decTag] <= 1'b0;
            end
            if (cdbValid) begin
                results[cdbTag] <= cdbData;
                done[cdbTag]    <= 1'b1;  // wins over a same-tag dispatch.
            end
        end
    end

    // ----------------------------------------
    // lookups with completion bypass
    // ----------------------------------------
    assign hit1 = cdbValid && cdbTag == lookTag1;
    assign hit2 = cdbValid && cdbTag == lookTag2;

    assign robReady1 = hit1 ? 1'b1 : done[lookTag1];
    assign robReady2 = hit2 ? 1'b1 : done[lookTag2];
    assign robData1  = hit1 ? cdbData : results[lookTag1];
    assign robData2  = hit2 ? cdbData : results[lookTag2];

    cdbTagNonZero: assert property (@(posedge clk) disable iff (rst)
        cdbValid |-> cdbTag != '0)
        else $error("completion carries tag 0");

endmodule

// File: src.f
+incdir+rtl
rtl/archPkg.sv
rtl/robPkg.sv
rtl/regFile.sv
rtl/robValues.sv
rtl/operandSelect.sv
rtl/operandFetch.sv
bench/operandFetchTb.sv
